/* verilog/pool_ctrl_pkg.sv */
package pool_ctrl_pkg;

  localparam int LWIDTH = 8; // sizes and coordinates

  typedef logic [LWIDTH-1:0] size_t;

  // latency seen from an accepted pixel
  localparam int D_POOLBUF = 1; // pixel to col_max
  localparam int D_POOL    = 2; // col_max to out_pixel

  typedef enum logic {
    s_wait,
    s_active
  } pool_state_t;

endpackage

/* verilog/pool_data_pkg.sv */
package pool_data_pkg;

  localparam int DWIDTH = 16;

  typedef logic signed [DWIDTH-1:0] pixel_t;

  // loses every compare
  localparam pixel_t PIXEL_MIN = {1'b1, {(DWIDTH-1){1'b0}}};

endpackage

/* verilog/ctrl_pool.sv */
module ctrl_pool
  import pool_ctrl_pkg::*;
  ( input  logic  clk
  , input  logic  xrst
  , input  logic  in_start
  , input  logic  in_valid
  , input  size_t fea_size
  , input  size_t pool_size
  , output logic  out_start
  , output logic  out_valid
  , output logic  out_stop
  , output size_t feat_addr
  , output logic  feat_first
  , output logic  feat_en
  , output logic  pool_first
  , output logic  pool_oe
  );

  pool_state_t state;
  size_t       fea_r;
  size_t       pool_r;
  size_t       pix_x;
  size_t       pix_y;
  size_t       win_x;
  size_t       win_y;
  logic        act_valid;
  logic        last_col;
  logic        last_row;
  logic        last_win_x;
  logic        last_win_y;
  logic        win_first;
  logic        win_start;
  logic        win_valid;
  logic        win_stop;

  logic [D_POOLBUF-1:0] buf_first;
  logic [D_POOLBUF-1:0] buf_start;
  logic [D_POOLBUF-1:0] buf_valid;
  logic [D_POOLBUF-1:0] buf_stop;
  logic [D_POOL-2:0]    pool_start; // leaves one stage early
  logic [D_POOL-1:0]    pool_valid;
  logic [D_POOL-1:0]    pool_stop;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state  <= s_wait;
      fea_r  <= '0;
      pool_r <= '0;
    end else begin
      case (state)
        s_wait: begin
          if (in_start) begin
            state  <= s_active;
            fea_r  <= fea_size;
            pool_r <= pool_size;
          end
        end
        s_active: begin
          if (out_stop) begin
            state <= s_wait; // last result is out
          end
        end
        default: state <= s_wait;
      endcase
    end
  end

  assign act_valid  = (state == s_active) && in_valid;
  assign last_col   = pix_x == fea_r - 1'b1;
  assign last_row   = pix_y == fea_r - 1'b1;
  assign last_win_x = win_x == pool_r - 1'b1;
  assign last_win_y = win_y == pool_r - 1'b1;

  always_ff @(posedge clk) begin
    if (!xrst || state == s_wait) begin
      pix_x <= '0;
      pix_y <= '0;
      win_x <= '0;
      win_y <= '0;
    end else if (act_valid) begin
      pix_x <= last_col ? '0 : pix_x + 1'b1;
      win_x <= last_win_x ? '0 : win_x + 1'b1;
      if (last_col) begin
        pix_y <= last_row ? '0 : pix_y + 1'b1;
        win_y <= last_win_y ? '0 : win_y + 1'b1;
      end
    end
  end

  // per-pixel window events before any delay
  assign win_first = act_valid && win_x == '0;
  assign win_valid = act_valid && last_win_x && last_win_y;
  assign win_start = act_valid && pix_x == pool_r - 1'b1 && pix_y == pool_r - 1'b1;
  assign win_stop  = act_valid && last_col && last_row;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      buf_first  <= '0;
      buf_start  <= '0;
      buf_valid  <= '0;
      buf_stop   <= '0;
      pool_start <= '0;
      pool_valid <= '0;
      pool_stop  <= '0;
    end else begin
      for (int i = D_POOLBUF - 1; i > 0; i--) begin
        buf_first[i] <= buf_first[i-1];
        buf_start[i] <= buf_start[i-1];
        buf_valid[i] <= buf_valid[i-1];
        buf_stop[i]  <= buf_stop[i-1];
      end
      buf_first[0] <= win_first;
      buf_start[0] <= win_start;
      buf_valid[0] <= win_valid;
      buf_stop[0]  <= win_stop;
      for (int i = D_POOL - 1; i > 0; i--) begin
        pool_valid[i] <= pool_valid[i-1];
        pool_stop[i]  <= pool_stop[i-1];
      end
      for (int i = D_POOL - 2; i > 0; i--) begin
        pool_start[i] <= pool_start[i-1];
      end
      pool_start[0] <= buf_start[D_POOLBUF-1];
      pool_valid[0] <= buf_valid[D_POOLBUF-1];
      pool_stop[0]  <= buf_stop[D_POOLBUF-1];
    end
  end

  assign feat_addr  = pix_x;
  assign feat_first = win_y == '0; // top row of the band
  assign feat_en    = act_valid;
  assign pool_first = buf_first[D_POOLBUF-1];
  assign pool_oe    = pool_valid[D_POOL-2];
  assign out_start  = pool_start[D_POOL-2];
  assign out_valid  = pool_valid[D_POOL-1];
  assign out_stop   = pool_stop[D_POOL-1];

endmodule

/* verilog/buf_feat.sv */
module buf_feat
  import pool_ctrl_pkg::*;
  import pool_data_pkg::*;
  #( parameter int MAX_FEA = 32
  )
  ( input  logic   clk
  , input  logic   xrst
  , input  logic   feat_en
  , input  logic   feat_first
  , input  size_t  feat_addr
  , input  pixel_t in_pixel
  , output pixel_t col_max
  );

  localparam int AW = $clog2(MAX_FEA);

  pixel_t        mem [MAX_FEA]; // one partial max per column
  logic [AW-1:0] addr;
  pixel_t        stored;
  pixel_t        wr_data;
  pixel_t        col_reg;

  assign addr = feat_addr[AW-1:0];

  // first row of a band starts the column over
  assign stored  = feat_first ? PIXEL_MIN : mem[addr];
  assign wr_data = (in_pixel > stored) ? in_pixel : stored;

  always_ff @(posedge clk) begin
    if (feat_en) begin
      mem[addr] <= wr_data;
    end
  end

  // held through input gaps
  always_ff @(posedge clk) begin
    if (!xrst) begin
      col_reg <= '0;
    end else if (feat_en) begin
      col_reg <= wr_data;
    end
  end

  assign col_max = col_reg;

endmodule

/* verilog/pool_max.sv */
module pool_max
  import pool_data_pkg::*;
  ( input  logic   clk
  , input  logic   xrst
  , input  logic   pool_first
  , input  logic   pool_oe
  , input  pixel_t col_max
  , output pixel_t out_pixel
  );

  pixel_t run_max; // max over columns seen in this window
  pixel_t base;
  pixel_t upd_max;
  pixel_t out_reg;

  assign base    = pool_first ? PIXEL_MIN : run_max; // new window
  assign upd_max = (col_max > base) ? col_max : base;

  // repeated col_max during a gap leaves the max unchanged
  always_ff @(posedge clk) begin
    run_max <= upd_max;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      out_reg <= '0;
    end else if (pool_oe) begin
      out_reg <= run_max; // holds until next window
    end
  end

  assign out_pixel = out_reg;

endmodule

/* verilog/pool_top.sv */
module pool_top
  import pool_ctrl_pkg::*;
  import pool_data_pkg::*;
  #( parameter int MAX_FEA = 32
  )
  ( input  logic   clk
  , input  logic   xrst
  , input  logic   in_start
  , input  logic   in_valid
  , input  pixel_t in_pixel
  , input  size_t  fea_size
  , input  size_t  pool_size
  , output logic   out_start
  , output logic   out_valid
  , output logic   out_stop
  , output pixel_t out_pixel
  );

  size_t  feat_addr;
  logic   feat_first;
  logic   feat_en;
  logic   pool_first;
  logic   pool_oe;
  pixel_t col_max;

  ctrl_pool u_ctrl_pool
    ( .clk        (clk)
    , .xrst       (xrst)
    , .in_start   (in_start)
    , .in_valid   (in_valid)
    , .fea_size   (fea_size)
    , .pool_size  (pool_size)
    , .out_start  (out_start)
    , .out_valid  (out_valid)
    , .out_stop   (out_stop)
    , .feat_addr  (feat_addr)
    , .feat_first (feat_first)
    , .feat_en    (feat_en)
    , .pool_first (pool_first)
    , .pool_oe    (pool_oe)
    );

  buf_feat #(.MAX_FEA(MAX_FEA)) u_buf_feat
    ( .clk        (clk)
    , .xrst       (xrst)
    , .feat_en    (feat_en)
    , .feat_first (feat_first)
    , .feat_addr  (feat_addr)
    , .in_pixel   (in_pixel)
    , .col_max    (col_max)
    );

  pool_max u_pool_max
    ( .clk        (clk)
    , .xrst       (xrst)
    , .pool_first (pool_first)
    , .pool_oe    (pool_oe)
    , .col_max    (col_max)
    , .out_pixel  (out_pixel)
    );

endmodule

/* test/clock_gen.sv */
module clock_gen
  ( output logic clk
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk; // period 4
    end
  end

endmodule

/* test/pool_assertions.sv */
module pool_assertions
  import pool_data_pkg::*;
  ( input logic   clk
  , input logic   xrst
  , input logic   in_start
  , input logic   out_start
  , input logic   out_valid
  , input logic   out_stop
  , input pixel_t out_pixel
  );

  logic in_frame; // accepted start up to last result

  always_ff @(posedge clk) begin
    if (!xrst) begin
      in_frame <= 1'b0;
    end else if (in_start) begin
      in_frame <= 1'b1;
    end else if (out_stop) begin
      in_frame <= 1'b0;
    end
  end

  reset_quiet: assert property (@(posedge clk)
    !xrst |=> !out_start && !out_valid && !out_stop && out_pixel == '0)
    else $error("outputs not low after a reset cycle");

  start_alone: assert property (@(posedge clk) disable iff (!xrst)
    !(out_start && out_valid))
    else $error("out_start and out_valid high together");

  stop_with_valid: assert property (@(posedge clk) disable iff (!xrst)
    out_stop |-> out_valid)
    else $error("out_stop without out_valid");

  valid_in_frame: assert property (@(posedge clk) disable iff (!xrst)
    out_valid |-> in_frame)
    else $error("out_valid outside a frame");

endmodule

/* test/pool_tb.sv */
module pool_tb
  import pool_ctrl_pkg::*;
  import pool_data_pkg::*;
  ();

  logic   clk;
  logic   xrst;
  logic   in_start;
  logic   in_valid;
  pixel_t in_pixel;
  size_t  fea_size;
  size_t  pool_size;
  logic   out_start;
  logic   out_valid;
  logic   out_stop;
  pixel_t out_pixel;

  int     seed;
  int     cyc; // posedges since reset
  int     frames_sent;
  int     frames_done;
  int     seen; // results so far in this frame
  int     start_cyc;
  logic   in_frame;
  pixel_t frame_q[$]; // raster pixels of the current frame
  pixel_t exp_q[$];
  int     due_q[$]; // cycle at which each result is due
  int     count_q[$];

  clock_gen u_clock_gen (.clk(clk));

  pool_top #(.MAX_FEA(32)) UUT
    ( .clk (clk), .xrst (xrst), .in_start (in_start), .in_valid (in_valid)
    , .in_pixel (in_pixel), .fea_size (fea_size), .pool_size (pool_size)
    , .out_start (out_start), .out_valid (out_valid), .out_stop (out_stop)
    , .out_pixel (out_pixel)
    );

  bind pool_top pool_assertions u_pool_assertions
    ( .clk (clk), .xrst (xrst), .in_start (in_start), .out_start (out_start)
    , .out_valid (out_valid), .out_stop (out_stop), .out_pixel (out_pixel)
    );

  always @(posedge clk) begin
    if (!xrst) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    if (actual != expected) begin
      stop_on_error($sformatf("Mismatch %s: expected %0d, actual %0d", name, expected, actual));
    end
  endtask

  // max over one pool x pool block of frame_q
  function automatic pixel_t window_max(input int fea, input int pool, input int wr, input int wc);
    pixel_t best;
    pixel_t pix;
    best = frame_q[wr * pool * fea + wc * pool];
    for (int r = 0; r < pool; r++) begin
      for (int c = 0; c < pool; c++) begin
        pix = frame_q[(wr * pool + r) * fea + wc * pool + c];
        if (pix > best) begin
          best = pix;
        end
      end
    end
    return best;
  endfunction

  // mode 0 ramp, 1 random, 2 repeat last pixels, 3 random negative
  task automatic send_frame(input int fea, input int pool, input int mode, input bit gaps);
    int     wait_cnt;
    pixel_t pix;
    if (mode != 2) begin
      frame_q.delete();
      for (int i = 0; i < fea * fea; i++) begin
        pix = mode == 0 ? pixel_t'(i) : pixel_t'($random(seed));
        if (mode == 3) begin
          pix[DWIDTH-1] = 1'b1; // sign bit forced
        end
        frame_q.push_back(pix);
      end
    end
    for (int wr = 0; wr < fea / pool; wr++) begin
      for (int wc = 0; wc < fea / pool; wc++) begin
        exp_q.push_back(window_max(fea, pool, wr, wc));
      end
    end
    count_q.push_back((fea / pool) * (fea / pool));
    wait_cnt = 0;
    while (frames_done < frames_sent) begin
      @(negedge clk);
      wait_cnt++;
      if (wait_cnt > 100) begin
        stop_on_error("timeout waiting for the previous frame to finish");
      end
    end
    fea_size  = size_t'(fea);
    pool_size = size_t'(pool);
    in_start  = 1'b1;
    @(negedge clk);
    in_start = 1'b0;
    frames_sent++;
    for (int i = 0; i < fea * fea; i++) begin
      if (gaps && ($random(seed) & 3) == 0) begin
        in_valid = 1'b0; // idle cycle
        @(negedge clk);
      end
      in_valid = 1'b1;
      in_pixel = frame_q[i];
      if ((i % fea) % pool == pool - 1 && (i / fea) % pool == pool - 1) begin
        due_q.push_back(cyc + 3);
      end
      @(negedge clk);
    end
    in_valid = 1'b0;
  endtask

  always @(negedge clk) begin
    if (!xrst) begin
      frames_done <= 0;
      in_frame  = 1'b0;
      seen      = 0;
    end else begin
      if (out_start) begin
        if (in_frame) begin
          stop_on_error("second out_start inside one frame");
        end
        in_frame  = 1'b1;
        seen      = 0;
        start_cyc = cyc;
      end
      if (out_valid) begin
        if (!in_frame || exp_q.size() == 0) begin
          stop_on_error("out_valid with no open frame or no expected result");
        end
        if (seen == 0) begin
          check_value($sformatf("frame %0d start lead", frames_done), start_cyc + 1, cyc);
        end
        check_value($sformatf("frame %0d pixel %0d", frames_done, seen),
                    int'(exp_q.pop_front()), int'(out_pixel));
        check_value($sformatf("frame %0d latency %0d", frames_done, seen),
                    due_q.pop_front(), cyc);
        seen++;
        if (out_stop) begin
          check_value($sformatf("frame %0d count", frames_done), count_q.pop_front(), seen);
          in_frame = 1'b0;
          frames_done <= frames_done + 1;
        end
      end
    end
  end

  initial begin
    int wait_cnt;
    seed        = 32'h153b7f3c;
    frames_sent = 0;
    xrst        = 1'b0;
    in_start    = 1'b0;
    in_valid    = 1'b0;
    in_pixel    = '0;
    fea_size    = '0;
    pool_size   = '0;
    @(negedge clk);
    @(negedge clk);
    xrst = 1'b1;
    send_frame(4, 2, 0, 1'b0); // ramp puts each max bottom right
    send_frame(6, 3, 1, 1'b0);
    send_frame(6, 3, 2, 1'b1); // same pixels with gaps
    send_frame(8, 4, 1, 1'b1);
    send_frame(4, 2, 3, 1'b0); // all windows negative
    wait_cnt = 0;
    while (frames_done < frames_sent) begin
      @(negedge clk);
      wait_cnt++;
      if (wait_cnt > 100) begin
        stop_on_error("timeout waiting for the last frame to finish");
      end
    end
    if (exp_q.size() != 0 || due_q.size() != 0) begin
      stop_on_error("expected results left over after the last frame");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

/* all.f */
verilog/pool_ctrl_pkg.sv
verilog/pool_data_pkg.sv
verilog/ctrl_pool.sv
verilog/buf_feat.sv
verilog/pool_max.sv
verilog/pool_top.sv
test/clock_gen.sv
test/pool_assertions.sv
test/pool_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the pooling testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module pool_tb \
  --Mdir obj_dir \
  -f all.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed"
  exit $status
fi

./obj_dir/Vpool_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed"
  exit $status
fi

exit 0
